//--- rtl/cpuPkg.sv
/* Widths, opcode encoding and sequencer states for the accumulator CPU.
   Opcode 15 is unassigned and executes as NOP. */
`default_nettype none

package cpuPkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------
    localparam int AddrWidth = 8;
    localparam int DataWidth = 16;
    localparam int OpWidth   = 4;

    typedef logic [AddrWidth-1:0] addrT;    // Memory address or immediate
    typedef logic [DataWidth-1:0] dataT;    // Memory word or accumulator
    typedef logic [OpWidth-1:0]   opcodeT;

    // ----------------------------------------
    // Instruction encoding, opcode in [15:12]
    // ----------------------------------------
    localparam opcodeT OpNop = 4'h0;
    localparam opcodeT OpLda = 4'h1;
    localparam opcodeT OpLdi = 4'h2;
    localparam opcodeT OpSta = 4'h3;
    localparam opcodeT OpAdd = 4'h4;
    localparam opcodeT OpSub = 4'h5;
    localparam opcodeT OpAnd = 4'h6;
    localparam opcodeT OpOr  = 4'h7;
    localparam opcodeT OpXor = 4'h8;
    localparam opcodeT OpShl = 4'h9;
    localparam opcodeT OpShr = 4'hA;
    localparam opcodeT OpJmp = 4'hB;
    localparam opcodeT OpJz  = 4'hC;
    localparam opcodeT OpJn  = 4'hD;
    localparam opcodeT OpHlt = 4'hE;

    // Sequencer states
    typedef enum logic [2:0] {
        StIdle, StFetch, StDecode, StExecute, StWriteback, StHalted
    } stateT;

endpackage

`default_nettype wire

//--- rtl/memory.sv
/* 256x16 single-port RAM, both ports sampled on the falling edge of Clk.
   Enables are active low; DOut is registered and holds when not reading. */
`timescale 1ns/1ps
`default_nettype none

module memory (
    input  wire            Clk,       // Falling edge active
    input  wire cpuPkg::dataT   DIn,
    input  wire cpuPkg::addrT   Address,
    input  wire            WriteEnN,  // Low for write
    input  wire            MemEnN,    // Low to access
    output cpuPkg::dataT   DOut       // Registered read data
);

    // Storage, no reset and no preload
    cpuPkg::dataT mem [0:(1 << cpuPkg::AddrWidth)-1];

    logic doWrite;
    logic doRead;

    // Decode the two access kinds
    assign doWrite = ~MemEnN & ~WriteEnN;
    assign doRead  = ~MemEnN &  WriteEnN;

    // ----------------------------------------
    // Write port
    // ----------------------------------------
    always_ff @(negedge Clk) begin
        if (doWrite) begin
            mem[Address] <= DIn;
        end
    end

    // ----------------------------------------
    // Registered read
    // ----------------------------------------
    // Old value stays on DOut during writes and idle cycles
    always_ff @(negedge Clk) begin
        if (doRead) begin
            DOut <= mem[Address];
        end
    end

endmodule

`default_nettype wire

//--- rtl/alu.sv
/* Purely combinational; result is the accumulator's next value.
   No carry or overflow is produced, arithmetic wraps at 16 bits. */
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  wire cpuPkg::opcodeT op,
    input  wire cpuPkg::dataT   a,       // Current accumulator
    input  wire cpuPkg::dataT   b,       // Memory word or immediate
    output cpuPkg::dataT        result
);

    cpuPkg::dataT sum;
    cpuPkg::dataT diff;

    // Adder and subtractor, carry out dropped
    assign sum  = a + b;
    assign diff = a - b;

    always_comb begin
        unique case (op)
            // Loads
            cpuPkg::OpLda,
            cpuPkg::OpLdi: result = b;

            // ----------------------------------------
            // Arithmetic
            // ----------------------------------------
            cpuPkg::OpAdd: result = sum;
            cpuPkg::OpSub: result = diff;

            // ----------------------------------------
            // Bitwise logic
            // ----------------------------------------
            cpuPkg::OpAnd: result = a & b;
            cpuPkg::OpOr:  result = a | b;
            cpuPkg::OpXor: result = a ^ b;

            // Single-bit shifts, zero fill
            cpuPkg::OpShl: result = {a[cpuPkg::DataWidth-2:0], 1'b0};
            cpuPkg::OpShr: result = {1'b0, a[cpuPkg::DataWidth-1:1]};

            // NOP, STA, jumps, HLT, code 15
            default:       result = a;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/dataPath.sv
/* PC, instruction register and accumulator, all on the rising edge.
   clear has priority over every other strobe; pcLoad beats pcInc. */
`timescale 1ns/1ps
`default_nettype none

module dataPath (
    input  wire                 Clk,
    input  wire                 rstN,
    input  wire                 irLoad,          // Capture memData into IR
    input  wire                 pcInc,
    input  wire                 pcLoad,          // Jump to operand field
    input  wire                 accLoad,         // Take ALU result
    input  wire                 addrSelOperand,  // Address from IR, else PC
    input  wire                 clear,           // Start of a run
    input  wire cpuPkg::dataT   memData,
    output cpuPkg::opcodeT      opcode,
    output logic                zero,
    output logic                negative,
    output cpuPkg::addrT        cpuAddr,
    output cpuPkg::dataT        acc
);

    cpuPkg::addrT pc;
    cpuPkg::dataT ir;
    cpuPkg::addrT operand;
    cpuPkg::dataT aluB;
    cpuPkg::dataT aluResult;

    // ----------------------------------------
    // Instruction fields
    // ----------------------------------------
    assign opcode  = ir[15:12];
    assign operand = ir[cpuPkg::AddrWidth-1:0];   // Bits 11:8 unused

    // Memory address mux
    assign cpuAddr = addrSelOperand ? operand : pc;

    // LDI zero-extends its immediate
    assign aluB = (opcode == cpuPkg::OpLdi)
                ? {{(cpuPkg::DataWidth - cpuPkg::AddrWidth){1'b0}}, operand}
                : memData;

    // Status flags straight off the accumulator
    assign zero     = (acc == '0);
    assign negative = acc[cpuPkg::DataWidth-1];

    alu uAlu (
        .op     (opcode),
        .a      (acc),
        .b      (aluB),
        .result (aluResult)
    );

    // ----------------------------------------
    // Program counter
    // ----------------------------------------
    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            pc <= '0;
        end else if (clear) begin
            pc <= '0;
        end else if (pcLoad) begin
            pc <= operand;
        end else if (pcInc) begin
            pc <= pc + 1'b1;   // Wraps past 0xFF
        end
    end

    // Instruction register, reset to NOP
    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            ir <= '0;
        end else if (irLoad) begin
            ir <= memData;
        end
    end

    // ----------------------------------------
    // Accumulator
    // ----------------------------------------
    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            acc <= '0;
        end else if (clear) begin
            acc <= '0;
        end else if (accLoad) begin
            acc <= aluResult;
        end
    end

endmodule

`default_nettype wire

//--- rtl/controlUnit.sv
/* Fetch/decode/execute sequencer and host/CPU arbiter for the memory port.
   Host inputs pass through only while not busy; they are ignored mid-run. */
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
    input  wire                 Clk,
    input  wire                 rstN,
    input  wire                 start,          // One-cycle pulse
    input  wire cpuPkg::opcodeT opcode,
    input  wire                 zero,
    input  wire                 negative,
    input  wire cpuPkg::addrT   cpuAddr,
    input  wire cpuPkg::dataT   acc,
    input  wire cpuPkg::addrT   hostAddr,
    input  wire cpuPkg::dataT   hostDIn,
    input  wire                 hostWriteEnN,
    input  wire                 hostMemEnN,
    output logic                irLoad,
    output logic                pcInc,
    output logic                pcLoad,
    output logic                accLoad,
    output logic                addrSelOperand,
    output logic                clear,
    output cpuPkg::addrT        memAddr,
    output cpuPkg::dataT        memDIn,
    output logic                memWriteEnN,
    output logic                memEnN,
    output logic                busy,
    output logic                halted
);

    cpuPkg::stateT state;
    cpuPkg::stateT nextState;

    logic cpuEnN;        // CPU side memory enable, low active
    logic cpuWriteEnN;   // CPU side write enable, low active
    logic memOperand;    // Opcode reads a data word
    logic jumpTaken;

    // Opcodes that need a second memory read and a writeback cycle
    assign memOperand = (opcode == cpuPkg::OpLda) || (opcode == cpuPkg::OpAdd) ||
                        (opcode == cpuPkg::OpSub) || (opcode == cpuPkg::OpAnd) ||
                        (opcode == cpuPkg::OpOr)  || (opcode == cpuPkg::OpXor);

    // Conditional branch decision
    assign jumpTaken = ((opcode == cpuPkg::OpJz) && zero) ||
                       ((opcode == cpuPkg::OpJn) && negative);

    assign busy   = (state != cpuPkg::StIdle) && (state != cpuPkg::StHalted);
    assign halted = (state == cpuPkg::StHalted);

    // ----------------------------------------
    // State register
    // ----------------------------------------
    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            state <= cpuPkg::StIdle;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            cpuPkg::StIdle,
            cpuPkg::StHalted:    if (start) nextState = cpuPkg::StFetch;
            cpuPkg::StFetch:     nextState = cpuPkg::StDecode;
            cpuPkg::StDecode:    nextState = cpuPkg::StExecute;
            cpuPkg::StExecute: begin
                if (memOperand) begin
                    nextState = cpuPkg::StWriteback;
                end else if (opcode == cpuPkg::OpHlt) begin
                    nextState = cpuPkg::StHalted;
                end else begin
                    nextState = cpuPkg::StFetch;
                end
            end
            cpuPkg::StWriteback: nextState = cpuPkg::StFetch;
            default:             nextState = cpuPkg::StIdle;
        endcase
    end

    // ----------------------------------------
    // Strobe decode
    // ----------------------------------------
    always_comb begin
        irLoad         = 1'b0;
        pcInc          = 1'b0;
        pcLoad         = 1'b0;
        accLoad        = 1'b0;
        addrSelOperand = 1'b0;
        clear          = 1'b0;
        cpuEnN         = 1'b1;
        cpuWriteEnN    = 1'b1;
        case (state)
            // Run restart clears PC and acc
            cpuPkg::StIdle,
            cpuPkg::StHalted: clear = start;
            // Read instruction at PC, lands on DOut at the falling edge
            cpuPkg::StFetch:  cpuEnN = 1'b0;
            cpuPkg::StDecode: begin
                irLoad = 1'b1;
                pcInc  = 1'b1;
            end
            cpuPkg::StExecute: begin
                if (memOperand) begin
                    addrSelOperand = 1'b1;
                    cpuEnN         = 1'b0;
                end
                case (opcode)
                    cpuPkg::OpSta: begin
                        addrSelOperand = 1'b1;
                        cpuEnN         = 1'b0;
                        cpuWriteEnN    = 1'b0;
                    end
                    cpuPkg::OpLdi,
                    cpuPkg::OpShl,
                    cpuPkg::OpShr: accLoad = 1'b1;
                    cpuPkg::OpJmp: pcLoad  = 1'b1;
                    cpuPkg::OpJz,
                    cpuPkg::OpJn:  pcLoad  = jumpTaken;
                    default:       ;
                endcase
            end
            // Operand word now on DOut
            cpuPkg::StWriteback: accLoad = 1'b1;
            default: ;
        endcase
    end

    // ----------------------------------------
    // Memory port arbitration
    // ----------------------------------------
    always_comb begin
        if (busy) begin
            memAddr     = cpuAddr;
            memDIn      = acc;
            memWriteEnN = cpuWriteEnN;
            memEnN      = cpuEnN;
        end else begin
            memAddr     = hostAddr;
            memDIn      = hostDIn;
            memWriteEnN = hostWriteEnN;
            memEnN      = hostMemEnN;
        end
    end

endmodule

`default_nettype wire

//--- rtl/cpuTop.sv
/* Accumulator CPU with host access to its 256x16 memory while idle or halted.
   hostDOut mirrors the memory read register at all times. */
`timescale 1ns/1ps
`default_nettype none

module cpuTop (
    input  wire                 Clk,
    input  wire                 rstN,
    input  wire                 start,
    input  wire cpuPkg::addrT   hostAddr,
    input  wire cpuPkg::dataT   hostDIn,
    input  wire                 hostWriteEnN,
    input  wire                 hostMemEnN,
    output cpuPkg::dataT        hostDOut,
    output logic                busy,
    output logic                halted,
    output cpuPkg::dataT        acc
);

    // Memory port after arbitration
    cpuPkg::addrT   memAddr;
    cpuPkg::dataT   memDIn;
    logic           memWriteEnN;
    logic           memEnN;

    // Data path status and control strobes
    cpuPkg::opcodeT opcode;
    cpuPkg::addrT   cpuAddr;
    logic           zero;
    logic           negative;
    logic           irLoad;
    logic           pcInc;
    logic           pcLoad;
    logic           accLoad;
    logic           addrSelOperand;
    logic           clear;

    memory uMemory (
        .Clk      (Clk),
        .DIn      (memDIn),
        .Address  (memAddr),
        .WriteEnN (memWriteEnN),
        .MemEnN   (memEnN),
        .DOut     (hostDOut)
    );

    dataPath uDataPath (
        .Clk            (Clk),
        .rstN           (rstN),
        .irLoad         (irLoad),
        .pcInc          (pcInc),
        .pcLoad         (pcLoad),
        .accLoad        (accLoad),
        .addrSelOperand (addrSelOperand),
        .clear          (clear),
        .memData        (hostDOut),
        .opcode         (opcode),
        .zero           (zero),
        .negative       (negative),
        .cpuAddr        (cpuAddr),
        .acc            (acc)
    );

    controlUnit uControlUnit (
        .Clk            (Clk),
        .rstN           (rstN),
        .start          (start),
        .opcode         (opcode),
        .zero           (zero),
        .negative       (negative),
        .cpuAddr        (cpuAddr),
        .acc            (acc),
        .hostAddr       (hostAddr),
        .hostDIn        (hostDIn),
        .hostWriteEnN   (hostWriteEnN),
        .hostMemEnN     (hostMemEnN),
        .irLoad         (irLoad),
        .pcInc          (pcInc),
        .pcLoad         (pcLoad),
        .accLoad        (accLoad),
        .addrSelOperand (addrSelOperand),
        .clear          (clear),
        .memAddr        (memAddr),
        .memDIn         (memDIn),
        .memWriteEnN    (memWriteEnN),
        .memEnN         (memEnN),
        .busy           (busy),
        .halted         (halted)
    );

endmodule

`default_nettype wire

//--- test/cpuTop_properties.sv
/* Checks on the arbitrated memory strobes and run status of cpuTop.
   Assumes the host never drives hostWriteEnN low without hostMemEnN low. */
`timescale 1ns/1ps
`default_nettype none

module cpuTop_properties (
    input wire Clk,
    input wire rstN,
    input wire start,
    input wire hostWriteEnN,
    input wire hostMemEnN,
    input wire memWriteEnN,
    input wire memEnN,
    input wire busy,
    input wire halted
);

    // Number of failed assertions so far
    int failCount = 0;

    // A write strobe only inside an enabled access
    writeNeedsEnable: assert property (@(posedge Clk) disable iff (!rstN)
        !memWriteEnN |-> !memEnN)
        else begin
            $error("memWriteEnN low while memEnN high");
            failCount++;
        end

    // Halted CPU leaves the port to the host
    haltedHostOnly: assert property (@(posedge Clk) disable iff (!rstN)
        halted |-> (memEnN == hostMemEnN) && (memWriteEnN == hostWriteEnN))
        else begin
            $error("Memory strobes not from host while halted");
            failCount++;
        end

    busyHaltedExclusive: assert property (@(posedge Clk) disable iff (!rstN)
        !(busy && halted))
        else begin
            $error("busy and halted high together");
            failCount++;
        end

    // busy rises only on the edge after a start pulse
    busyNeedsStart: assert property (@(posedge Clk) disable iff (!rstN)
        $rose(busy) |-> $past(start))
        else begin
            $error("busy rose without start");
            failCount++;
        end

endmodule

bind cpuTop cpuTop_properties props0 (
    .Clk          (Clk),
    .rstN         (rstN),
    .start        (start),
    .hostWriteEnN (hostWriteEnN),
    .hostMemEnN   (hostMemEnN),
    .memWriteEnN  (memWriteEnN),
    .memEnN       (memEnN),
    .busy         (busy),
    .halted       (halted)
);

`default_nettype wire

//--- test/cpuTb.sv
/* Runs from the project root and reads test/cpuVectors.txt. Every program starts at address 0.
   Address F0 is the target of host writes during each run and must keep its value. */
`timescale 1ns/1ps
`default_nettype none

module cpuTb;

    localparam int ClkPeriod   = 8;
    localparam int ResetCycles = 5;
    localparam int RunTimeout  = 2000;   // Cycles allowed per run
    localparam int RoundTrips  = 24;
    localparam logic [31:0] Seed = 32'he0b5_f395;

    // Host writes aimed here while busy must be dropped
    localparam cpuPkg::addrT ScratchAddr = 8'hF0;
    localparam cpuPkg::dataT ScratchJunk = 16'hBAD0;

    logic         Clk;
    logic         rstN;
    logic         start;
    cpuPkg::addrT hostAddr;
    cpuPkg::dataT hostDIn;
    logic         hostWriteEnN;
    logic         hostMemEnN;
    cpuPkg::dataT hostDOut;
    logic         busy;
    logic         halted;
    cpuPkg::dataT acc;

    // Round trip bookkeeping
    cpuPkg::addrT addrList [RoundTrips];
    cpuPkg::dataT shadow [256];

    cpuTop dut0 (
        .Clk          (Clk),
        .rstN         (rstN),
        .start        (start),
        .hostAddr     (hostAddr),
        .hostDIn      (hostDIn),
        .hostWriteEnN (hostWriteEnN),
        .hostMemEnN   (hostMemEnN),
        .hostDOut     (hostDOut),
        .busy         (busy),
        .halted       (halted),
        .acc          (acc)
    );

    initial begin
        Clk = 1'b0;
        forever #(ClkPeriod / 2) Clk = ~Clk;
    end

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    task automatic failNow(input string reason);
        $display("%0s", reason);
        $display("** FAIL **");
        $fatal(1, "Stopped at first error");
    endtask

    // Bound assertions on cpuTop count their failures
    always @(dut0.props0.failCount) begin
        if (dut0.props0.failCount != 0) begin
            failNow("A bound assertion on cpuTop failed");
        end
    end

    task automatic checkData(input string testName, input cpuPkg::dataT expected,
                             input cpuPkg::dataT actual);
        if (actual !== expected) begin
            failNow($sformatf("ERROR %0s: expected %h, actual %h", testName, expected, actual));
        end
    endtask

    task automatic checkAddr(input string testName, input cpuPkg::addrT expected,
                             input cpuPkg::addrT actual);
        if (actual !== expected) begin
            failNow($sformatf("ERROR %0s: expected %h, actual %h", testName, expected, actual));
        end
    endtask

    // Inputs change 1 ns after the rising edge
    task automatic nextCycle();
        @(posedge Clk);
        #1;
    endtask

    task automatic hostWrite(input cpuPkg::addrT addr, input cpuPkg::dataT data);
        hostAddr     = addr;
        hostDIn      = data;
        hostWriteEnN = 1'b0;
        hostMemEnN   = 1'b0;
        nextCycle();
        hostWriteEnN = 1'b1;
        hostMemEnN   = 1'b1;
    endtask

    // Read data lands at the falling edge, valid one rising edge later
    task automatic hostRead(input cpuPkg::addrT addr, output cpuPkg::dataT data);
        hostAddr     = addr;
        hostWriteEnN = 1'b1;
        hostMemEnN   = 1'b0;
        nextCycle();
        hostMemEnN   = 1'b1;
        data         = hostDOut;
    endtask

    // ----------------------------------------
    // Program run with host writes while busy
    // ----------------------------------------
    task automatic runProgram(input string testName, input cpuPkg::dataT expAcc);
        int cycles;
        start = 1'b1;
        nextCycle();
        start = 1'b0;
        if (!busy) begin
            failNow($sformatf("busy did not rise after start in test %0s", testName));
        end
        // PC and acc clear on the start edge
        checkData(testName, '0, acc);
        cycles = 0;
        while (!halted) begin
            if (busy) begin
                hostAddr     = ScratchAddr;
                hostDIn      = ScratchJunk;
                hostWriteEnN = 1'b0;
                hostMemEnN   = 1'b0;
            end
            nextCycle();
            cycles++;
            if (cycles > RunTimeout) begin
                failNow($sformatf("Timeout waiting for halted in test %0s", testName));
            end
        end
        // Released before the falling edge that would write
        hostWriteEnN = 1'b1;
        hostMemEnN   = 1'b1;
        checkData(testName, expAcc, acc);
    endtask

    // Low byte of each word is its own address to catch aliasing
    task automatic roundTrip();
        cpuPkg::addrT addr;
        cpuPkg::dataT word;
        cpuPkg::dataT readBack;
        for (int i = 0; i < RoundTrips; i++) begin
            addr        = cpuPkg::addrT'($urandom);
            word        = cpuPkg::dataT'($urandom);
            word[7:0]   = addr;
            addrList[i] = addr;
            shadow[addr] = word;
            hostWrite(addr, word);
        end
        // Second read proves a read leaves the word alone
        for (int i = 0; i < RoundTrips; i++) begin
            addr = addrList[i];
            for (int pass = 0; pass < 2; pass++) begin
                hostRead(addr, readBack);
                checkAddr("roundTrip", addr, readBack[7:0]);
                checkData("roundTrip", shadow[addr], readBack);
            end
        end
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        int               fd;
        int               code;
        logic             done;
        logic [7:0]       cmd;
        logic [8*16-1:0]  nameBuf;
        logic [8*128-1:0] lineBuf;
        cpuPkg::addrT     vecAddr;
        cpuPkg::dataT     vecData;
        cpuPkg::dataT     readBack;
        void'($urandom(Seed));
        rstN         = 1'b0;
        start        = 1'b0;
        hostAddr     = '0;
        hostDIn      = '0;
        hostWriteEnN = 1'b1;
        hostMemEnN   = 1'b1;
        repeat (ResetCycles) @(posedge Clk);
        #1;
        rstN = 1'b1;
        nextCycle();
        if (busy || halted) begin
            failNow("busy or halted is high after reset");
        end
        checkData("reset", '0, acc);

        roundTrip();

        fd = $fopen("test/cpuVectors.txt", "r");
        if (fd == 0) begin
            failNow("Could not open test/cpuVectors.txt");
        end
        done = 1'b0;
        while (!done) begin
            code = $fscanf(fd, "%s", cmd);
            if (code != 1) begin
                done = 1'b1;
            end else begin
                case (cmd)
                    "#": code = $fgets(lineBuf, fd);
                    "W": begin
                        code = $fscanf(fd, "%h %h", vecAddr, vecData);
                        if (code != 2) failNow("Malformed W record in vector file");
                        hostWrite(vecAddr, vecData);
                    end
                    "R": begin
                        code = $fscanf(fd, "%s %h", nameBuf, vecData);
                        if (code != 2) failNow("Malformed R record in vector file");
                        runProgram($sformatf("%0s", nameBuf), vecData);
                    end
                    "C": begin
                        code = $fscanf(fd, "%s %h %h", nameBuf, vecAddr, vecData);
                        if (code != 3) failNow("Malformed C record in vector file");
                        hostRead(vecAddr, readBack);
                        checkData($sformatf("%0s", nameBuf), vecData, readBack);
                    end
                    default: failNow($sformatf("Unknown command %0s in vector file", cmd));
                endcase
            end
        end
        $fclose(fd);

        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

//--- test/cpuVectors.txt
# W addr data          host write, values in hex
# R test acc           start, wait for halted, compare acc
# C test addr data     host read and compare
W F0 1234
# Arithmetic with LDA ADD SUB STA and 16-bit wrap
W 80 FFF0
W 81 0025
W 82 0100
W 00 1080
W 01 4081
W 02 3090
W 03 5082
W 04 3091
W 05 E000
R arith FF15
C arith 90 0015
C arith 91 FF15
# LDI then OR AND XOR SHL SHR
W 83 0F00
W 84 FF0F
W 85 A5A5
W 00 205A
W 01 7083
W 02 6084
W 03 8085
W 04 9000
W 05 3092
W 06 A000
W 07 E000
R logic 2AAF
C logic 92 555E
# Second start clears acc and reruns the same program
R restart 2AAF
C restart 92 555E
# Countdown from 3 with JZ and JMP then JN on FFFF
W 86 0003
W 87 0001
W 94 0000
W 00 1086
W 01 3093
W 02 1093
W 03 C00A
W 04 5087
W 05 3093
W 06 1094
W 07 4087
W 08 3094
W 09 B002
W 0A 5087
W 0B D00D
W 0C E000
W 0D 2077
W 0E E000
R branch 0077
C branch 93 0000
C branch 94 0003
# Host writes during runs must not reach F0
C busyWrite F0 1234

//--- project.f
rtl/cpuPkg.sv
rtl/memory.sv
rtl/alu.sv
rtl/dataPath.sv
rtl/controlUnit.sv
rtl/cpuTop.sv
test/cpuTop_properties.sv
test/cpuTb.sv

//--- Bender.yml
package:
  name: accumulator_cpu

sources:
  - rtl/cpuPkg.sv
  - rtl/memory.sv
  - rtl/alu.sv
  - rtl/dataPath.sv
  - rtl/controlUnit.sv
  - rtl/cpuTop.sv
  - target: test
    files:
      - test/cpuTop_properties.sv
      - test/cpuTb.sv
